/* source/robot_cmd_pkg.sv */
// ------------------------------
// robot command opcodes, field widths,
// step sizes and wrap limits
// ------------------------------
`default_nettype none

package robot_cmd_pkg;

  // opcode byte sent first in every frame
  typedef enum logic [3:0] {
    // reserved, a press here only moves the selector
    CMD_PWM_LEFT   = 4'd0,
    CMD_PWM_RGHT   = 4'd1,
    CMD_DPS_LIMIT  = 4'd2,
    CMD_DPS_LEFT   = 4'd3,
    CMD_DPS_RGHT   = 4'd4,
    CMD_EYE_LEFT   = 4'd5,
    CMD_EYE_RGHT   = 4'd6,
    CMD_BLINK_LEFT = 4'd7,
    CMD_BLINK_RGHT = 4'd8,
    CMD_SERVO_1    = 4'd9,
    CMD_SERVO_2    = 4'd10
  } cmd_e;

  // field widths
  localparam int DPS_W   = 16;
  localparam int RGB_W   = 24;
  localparam int SERVO_W = 10;

  // selector start, reserved opcodes skipped
  localparam cmd_e CMD_FIRST = CMD_DPS_LEFT;

  // wheel speed in degrees per second
  localparam logic [DPS_W-1:0] DPS_LEFT_STEP = 16'd32;
  localparam logic [DPS_W-1:0] DPS_RGHT_STEP = 16'd400;
  localparam logic [DPS_W-1:0] DPS_LIMIT     = 16'd900;
  // negative speed once the right wheel wraps
  localparam logic [DPS_W-1:0] DPS_RGHT_WRAP = 16'h8000;

  // per channel colour step and clear limits
  localparam logic [7:0] RGB_STEP    = 8'd32;
  localparam logic [7:0] EYE_LIMIT   = 8'd64;
  localparam logic [7:0] BLINK_LIMIT = 8'd128;

  // servo position, -500 and +500 are the end stops
  localparam logic signed [SERVO_W-1:0] SERVO_STEP  = 10'sd32;
  localparam logic signed [SERVO_W-1:0] SERVO_LIMIT = 10'sd480;
  localparam logic signed [SERVO_W-1:0] SERVO_START = 10'sd500;

endpackage

`default_nettype wire

/* source/spi_link_pkg.sv */
// ------------------------------
// spi divider, frame byte counts, master states
// ------------------------------
`default_nettype none

package spi_link_pkg;

  // system clocks per half sclk period
  localparam int SPI_HALF_DIV = 4;
  localparam int HALF_CNT_W   = $clog2(SPI_HALF_DIV);

  // longest payload is one rgb colour
  localparam int PAYLOAD_MAX = 3;
  localparam int PAYLOAD_W   = PAYLOAD_MAX * 8;
  localparam int CNT_W       = $clog2(PAYLOAD_MAX + 1);

  // payload bytes after the opcode byte
  localparam logic [CNT_W-1:0] PAYLOAD_BYTES_DPS   = 2'd2;
  localparam logic [CNT_W-1:0] PAYLOAD_BYTES_RGB   = 2'd3;
  localparam logic [CNT_W-1:0] PAYLOAD_BYTES_SERVO = 2'd2;
  // servo goes out sign extended to this width
  localparam int SERVO_TX_W = 16;

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    SHIFT,
    HOLD
  } spi_state_e;

endpackage

`default_nettype wire

/* source/btn_cmd_stepper.sv */
// ------------------------------
// button sync, press detect, command
// selector and robot setting registers
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module btn_cmd_stepper (
  input  wire                                     rst,
  input  wire                                     clk,
  input  wire                                     btn2_i,
  input  wire                                     busy_i,
  output logic                                    upd_o,
  output robot_cmd_pkg::cmd_e                     upd_cmd_o,
  output logic [robot_cmd_pkg::DPS_W-1:0]         dps_left_o,
  output logic [robot_cmd_pkg::DPS_W-1:0]         dps_rght_o,
  output logic [robot_cmd_pkg::RGB_W-1:0]         eye_left_o,
  output logic [robot_cmd_pkg::RGB_W-1:0]         eye_rght_o,
  output logic [robot_cmd_pkg::RGB_W-1:0]         blink_left_o,
  output logic [robot_cmd_pkg::RGB_W-1:0]         blink_rght_o,
  output logic signed [robot_cmd_pkg::SERVO_W-1:0] servo_1_o,
  output logic signed [robot_cmd_pkg::SERVO_W-1:0] servo_2_o
);

  // two sync stages plus one for edge detect
  logic btn_s1_q;
  logic btn_s2_q;
  logic btn_d_q;
  logic press;
  robot_cmd_pkg::cmd_e sel_q;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      btn_s1_q <= 1'b0;
      btn_s2_q <= 1'b0;
      btn_d_q  <= 1'b0;
    end else begin
      btn_s1_q <= btn2_i;
      btn_s2_q <= btn_s1_q;
      btn_d_q  <= btn_s2_q;
    end
  end

  // presses during a frame are dropped, not queued
  assign press = btn_s2_q & ~btn_d_q & ~busy_i;

  // selector walks all opcodes, reserved ones too
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      sel_q <= robot_cmd_pkg::CMD_FIRST;
    end else if (press) begin
      if (sel_q == robot_cmd_pkg::CMD_SERVO_2) begin
        sel_q <= robot_cmd_pkg::CMD_PWM_LEFT;
      end else begin
        sel_q <= robot_cmd_pkg::cmd_e'(sel_q + 4'd1);
      end
    end
  end

  // field update, each rule looks at the value before the press
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      upd_o        <= 1'b0;
      upd_cmd_o    <= robot_cmd_pkg::CMD_FIRST;
      dps_left_o   <= '0;
      dps_rght_o   <= '0;
      eye_left_o   <= '0;
      eye_rght_o   <= '0;
      blink_left_o <= '0;
      blink_rght_o <= '0;
      servo_1_o    <= '0;
      servo_2_o    <= '0;
    end else begin
      upd_o <= 1'b0;
      if (press) begin
        upd_cmd_o <= sel_q;
        upd_o     <= 1'b1;
        case (sel_q)
          robot_cmd_pkg::CMD_DPS_LEFT: begin
            if (dps_left_o >= robot_cmd_pkg::DPS_LIMIT) begin
              dps_left_o <= '0;
            end else begin
              dps_left_o <= dps_left_o + robot_cmd_pkg::DPS_LEFT_STEP;
            end
          end
          robot_cmd_pkg::CMD_DPS_RGHT: begin
            // unsigned compare, 0x8000 counts as large
            if (dps_rght_o >= robot_cmd_pkg::DPS_LIMIT) begin
              dps_rght_o <= robot_cmd_pkg::DPS_RGHT_WRAP;
            end else begin
              dps_rght_o <= dps_rght_o + robot_cmd_pkg::DPS_RGHT_STEP;
            end
          end
          robot_cmd_pkg::CMD_EYE_LEFT: begin
            // blue byte
            if (eye_left_o[7:0] >= robot_cmd_pkg::EYE_LIMIT) begin
              eye_left_o <= '0;
            end else begin
              eye_left_o[7:0] <= eye_left_o[7:0] + robot_cmd_pkg::RGB_STEP;
            end
          end
          robot_cmd_pkg::CMD_EYE_RGHT: begin
            // green byte
            if (eye_rght_o[15:8] >= robot_cmd_pkg::EYE_LIMIT) begin
              eye_rght_o <= '0;
            end else begin
              eye_rght_o[15:8] <= eye_rght_o[15:8] + robot_cmd_pkg::RGB_STEP;
            end
          end
          robot_cmd_pkg::CMD_BLINK_LEFT: begin
            // red byte
            if (blink_left_o[23:16] >= robot_cmd_pkg::BLINK_LIMIT) begin
              blink_left_o <= '0;
            end else begin
              blink_left_o[23:16] <= blink_left_o[23:16] + robot_cmd_pkg::RGB_STEP;
            end
          end
          robot_cmd_pkg::CMD_BLINK_RGHT: begin
            // blue decides, all three channels step together
            if (blink_rght_o[7:0] >= robot_cmd_pkg::BLINK_LIMIT) begin
              blink_rght_o <= '0;
            end else begin
              blink_rght_o[7:0]   <= blink_rght_o[7:0] + robot_cmd_pkg::RGB_STEP;
              blink_rght_o[15:8]  <= blink_rght_o[15:8] + robot_cmd_pkg::RGB_STEP;
              blink_rght_o[23:16] <= blink_rght_o[23:16] + robot_cmd_pkg::RGB_STEP;
            end
          end
          robot_cmd_pkg::CMD_SERVO_1: begin
            // sweeps upward, jumps to the lower stop
            if (servo_1_o >= robot_cmd_pkg::SERVO_LIMIT) begin
              servo_1_o <= -robot_cmd_pkg::SERVO_START;
            end else begin
              servo_1_o <= servo_1_o + robot_cmd_pkg::SERVO_STEP;
            end
          end
          robot_cmd_pkg::CMD_SERVO_2: begin
            // sweeps downward, jumps to the upper stop
            if (servo_2_o <= -robot_cmd_pkg::SERVO_LIMIT) begin
              servo_2_o <= robot_cmd_pkg::SERVO_START;
            end else begin
              servo_2_o <= servo_2_o - robot_cmd_pkg::SERVO_STEP;
            end
          end
          robot_cmd_pkg::CMD_PWM_LEFT,
          robot_cmd_pkg::CMD_PWM_RGHT,
          robot_cmd_pkg::CMD_DPS_LIMIT: begin
            // reserved, no frame
            upd_o <= 1'b0;
          end
          default: begin
            upd_o <= 1'b0;
          end
        endcase
      end
    end
  end

  // a new frame may only start once the builder is idle again
  a_no_upd_when_busy: assert property (
    @(posedge rst) disable iff (clk) upd_o |-> !busy_i
  );

endmodule

`default_nettype wire

/* source/cmd_frame_builder.sv */
// ------------------------------
// frame byte sequencing, link status
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module cmd_frame_builder (
  input  wire                                     rst,
  input  wire                                     clk,
  input  wire                                     upd_i,
  input  wire robot_cmd_pkg::cmd_e                upd_cmd_i,
  input  wire [robot_cmd_pkg::DPS_W-1:0]          dps_left_i,
  input  wire [robot_cmd_pkg::DPS_W-1:0]          dps_rght_i,
  input  wire [robot_cmd_pkg::RGB_W-1:0]          eye_left_i,
  input  wire [robot_cmd_pkg::RGB_W-1:0]          eye_rght_i,
  input  wire [robot_cmd_pkg::RGB_W-1:0]          blink_left_i,
  input  wire [robot_cmd_pkg::RGB_W-1:0]          blink_rght_i,
  input  wire signed [robot_cmd_pkg::SERVO_W-1:0] servo_1_i,
  input  wire signed [robot_cmd_pkg::SERVO_W-1:0] servo_2_i,
  input  wire                                     byte_done_i,
  input  wire [7:0]                               rx_byte_i,
  input  wire                                     frame_end_i,
  output logic                                    busy_o,
  output logic                                    tx_start_o,
  output logic [7:0]                              tx_byte_o,
  output logic                                    tx_last_o,
  output logic                                    rpi_running_o,
  output logic [7:0]                              status_o
);

  logic [spi_link_pkg::PAYLOAD_W-1:0]          snap;
  logic [spi_link_pkg::CNT_W-1:0]              snap_len;
  logic signed [spi_link_pkg::SERVO_TX_W-1:0]  srv_1_ext;
  logic signed [spi_link_pkg::SERVO_TX_W-1:0]  srv_2_ext;
  logic [spi_link_pkg::PAYLOAD_W-1:0]          pay_q;
  logic [spi_link_pkg::CNT_W-1:0]              left_q;

  // pick the changed field, msb first, left aligned in the payload
  always_comb begin
    // signed to signed, so the assignment sign extends
    srv_1_ext = servo_1_i;
    srv_2_ext = servo_2_i;
    snap      = '0;
    snap_len  = spi_link_pkg::PAYLOAD_BYTES_DPS;
    case (upd_cmd_i)
      robot_cmd_pkg::CMD_DPS_LEFT:   snap = {dps_left_i, 8'h00};
      robot_cmd_pkg::CMD_DPS_RGHT:   snap = {dps_rght_i, 8'h00};
      robot_cmd_pkg::CMD_EYE_LEFT: begin
        snap     = eye_left_i;
        snap_len = spi_link_pkg::PAYLOAD_BYTES_RGB;
      end
      robot_cmd_pkg::CMD_EYE_RGHT: begin
        snap     = eye_rght_i;
        snap_len = spi_link_pkg::PAYLOAD_BYTES_RGB;
      end
      robot_cmd_pkg::CMD_BLINK_LEFT: begin
        snap     = blink_left_i;
        snap_len = spi_link_pkg::PAYLOAD_BYTES_RGB;
      end
      robot_cmd_pkg::CMD_BLINK_RGHT: begin
        snap     = blink_rght_i;
        snap_len = spi_link_pkg::PAYLOAD_BYTES_RGB;
      end
      robot_cmd_pkg::CMD_SERVO_1: begin
        snap     = {srv_1_ext, 8'h00};
        snap_len = spi_link_pkg::PAYLOAD_BYTES_SERVO;
      end
      robot_cmd_pkg::CMD_SERVO_2: begin
        snap     = {srv_2_ext, 8'h00};
        snap_len = spi_link_pkg::PAYLOAD_BYTES_SERVO;
      end
      default: snap = '0;
    endcase
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      busy_o        <= 1'b0;
      tx_start_o    <= 1'b0;
      tx_byte_o     <= '0;
      tx_last_o     <= 1'b0;
      rpi_running_o <= 1'b0;
      status_o      <= '0;
      pay_q         <= '0;
      left_q        <= '0;
    end else begin
      tx_start_o <= 1'b0;
      if (upd_i) begin
        // opcode byte goes first
        busy_o     <= 1'b1;
        tx_start_o <= 1'b1;
        tx_byte_o  <= {4'h0, upd_cmd_i};
        tx_last_o  <= 1'b0;
        pay_q      <= snap;
        left_q     <= snap_len;
      end else if (byte_done_i && left_q != '0) begin
        // next payload byte, ready before the master loads it
        tx_byte_o <= pay_q[spi_link_pkg::PAYLOAD_W-1 -: 8];
        pay_q     <= pay_q << 8;
        left_q    <= left_q - 1'b1;
        tx_last_o <= (left_q == 1);
      end
      // reply byte clocked in with the final byte
      if (byte_done_i && tx_last_o) begin
        status_o <= rx_byte_i;
      end
      if (frame_end_i) begin
        busy_o        <= 1'b0;
        rpi_running_o <= 1'b1;
      end
    end
  end

  // the master only finishes bytes of a frame this block opened
  a_done_in_frame: assert property (
    @(posedge rst) disable iff (clk) byte_done_i |-> busy_o
  );

endmodule

`default_nettype wire

/* source/spi_byte_master.sv */
// ------------------------------
// spi mode 0 byte master
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module spi_byte_master (
  input  wire        rst,
  input  wire        clk,
  input  wire        tx_start_i,
  input  wire  [7:0] tx_byte_i,
  input  wire        tx_last_i,
  input  wire        miso_i,
  output logic       sclk_o,
  output logic       mosi_o,
  output logic       spi_ss_n_o,
  output logic       byte_done_o,
  output logic [7:0] rx_byte_o,
  output logic       frame_end_o
);

  spi_link_pkg::spi_state_e             state_q;
  logic [spi_link_pkg::HALF_CNT_W-1:0]  div_q;
  logic [2:0]                           bit_q;
  logic [7:0]                           tx_sh_q;
  logic [7:0]                           rx_sh_q;
  logic                                 last_q;
  logic                                 ld_q;
  logic                                 half_end;

  // end of a half sclk period
  assign half_end = (div_q == spi_link_pkg::SPI_HALF_DIV - 1);

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state_q     <= spi_link_pkg::IDLE;
      div_q       <= '0;
      bit_q       <= '0;
      tx_sh_q     <= '0;
      rx_sh_q     <= '0;
      last_q      <= 1'b0;
      ld_q        <= 1'b0;
      sclk_o      <= 1'b0;
      mosi_o      <= 1'b0;
      spi_ss_n_o  <= 1'b1;
      byte_done_o <= 1'b0;
      rx_byte_o   <= '0;
      frame_end_o <= 1'b0;
    end else begin
      byte_done_o <= 1'b0;
      frame_end_o <= 1'b0;
      // builder has the next byte ready one cycle after byte_done
      ld_q <= byte_done_o && (state_q == spi_link_pkg::SHIFT);
      if (state_q == spi_link_pkg::IDLE || half_end) begin
        div_q <= '0;
      end else begin
        div_q <= div_q + 1'b1;
      end
      case (state_q)
        spi_link_pkg::IDLE: begin
          if (tx_start_i) begin
            // msb on the line before the first rise
            spi_ss_n_o <= 1'b0;
            tx_sh_q    <= tx_byte_i;
            mosi_o     <= tx_byte_i[7];
            last_q     <= tx_last_i;
            bit_q      <= '0;
            state_q    <= spi_link_pkg::SETUP;
          end
        end
        spi_link_pkg::SETUP: begin
          // first rise, first miso sample
          if (half_end) begin
            sclk_o  <= 1'b1;
            rx_sh_q <= {rx_sh_q[6:0], miso_i};
            state_q <= spi_link_pkg::SHIFT;
          end
        end
        spi_link_pkg::SHIFT: begin
          if (ld_q) begin
            tx_sh_q <= tx_byte_i;
            mosi_o  <= tx_byte_i[7];
            last_q  <= tx_last_i;
          end
          if (half_end) begin
            sclk_o <= ~sclk_o;
            if (!sclk_o) begin
              // rising edge, sample
              rx_sh_q <= {rx_sh_q[6:0], miso_i};
            end else begin
              // falling edge, shift
              bit_q <= bit_q + 1'b1;
              if (bit_q == 3'd7) begin
                byte_done_o <= 1'b1;
                rx_byte_o   <= rx_sh_q;
                if (last_q) begin
                  mosi_o  <= 1'b0;
                  state_q <= spi_link_pkg::HOLD;
                end
              end else begin
                tx_sh_q <= {tx_sh_q[6:0], 1'b0};
                mosi_o  <= tx_sh_q[6];
              end
            end
          end
        end
        spi_link_pkg::HOLD: begin
          // ss stays low one more half period
          if (half_end) begin
            spi_ss_n_o  <= 1'b1;
            frame_end_o <= 1'b1;
            state_q     <= spi_link_pkg::IDLE;
          end
        end
        default: state_q <= spi_link_pkg::IDLE;
      endcase
    end
  end

  // no clock toggles outside a frame
  a_sclk_idle_low: assert property (
    @(posedge rst) disable iff (clk) spi_ss_n_o |-> !sclk_o
  );

endmodule

`default_nettype wire

/* source/robot_spi_top.sv */
// ------------------------------
// button to spi command link top
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module robot_spi_top (
  input  wire        rst,
  input  wire        clk,
  input  wire        btn2_i,
  input  wire        miso_i,
  output wire        sclk_o,
  output wire        mosi_o,
  output wire        spi_ss_n_o,
  output wire        rpi_running_o,
  output wire  [7:0] status_o
);

  // stepper to builder
  wire                                     upd;
  wire robot_cmd_pkg::cmd_e                upd_cmd;
  wire [robot_cmd_pkg::DPS_W-1:0]          dps_left;
  wire [robot_cmd_pkg::DPS_W-1:0]          dps_rght;
  wire [robot_cmd_pkg::RGB_W-1:0]          eye_left;
  wire [robot_cmd_pkg::RGB_W-1:0]          eye_rght;
  wire [robot_cmd_pkg::RGB_W-1:0]          blink_left;
  wire [robot_cmd_pkg::RGB_W-1:0]          blink_rght;
  wire signed [robot_cmd_pkg::SERVO_W-1:0] servo_1;
  wire signed [robot_cmd_pkg::SERVO_W-1:0] servo_2;
  // back pressure
  wire                                     busy;
  // builder and master
  wire                                     tx_start;
  wire [7:0]                               tx_byte;
  wire                                     tx_last;
  wire                                     byte_done;
  wire [7:0]                               rx_byte;
  wire                                     frame_end;

  btn_cmd_stepper btn_cmd_stepper_inst (
    .rst          (rst),
    .clk          (clk),
    .btn2_i       (btn2_i),
    .busy_i       (busy),
    .upd_o        (upd),
    .upd_cmd_o    (upd_cmd),
    .dps_left_o   (dps_left),
    .dps_rght_o   (dps_rght),
    .eye_left_o   (eye_left),
    .eye_rght_o   (eye_rght),
    .blink_left_o (blink_left),
    .blink_rght_o (blink_rght),
    .servo_1_o    (servo_1),
    .servo_2_o    (servo_2)
  );

  cmd_frame_builder cmd_frame_builder_inst (
    .rst           (rst),
    .clk           (clk),
    .upd_i         (upd),
    .upd_cmd_i     (upd_cmd),
    .dps_left_i    (dps_left),
    .dps_rght_i    (dps_rght),
    .eye_left_i    (eye_left),
    .eye_rght_i    (eye_rght),
    .blink_left_i  (blink_left),
    .blink_rght_i  (blink_rght),
    .servo_1_i     (servo_1),
    .servo_2_i     (servo_2),
    .byte_done_i   (byte_done),
    .rx_byte_i     (rx_byte),
    .frame_end_i   (frame_end),
    .busy_o        (busy),
    .tx_start_o    (tx_start),
    .tx_byte_o     (tx_byte),
    .tx_last_o     (tx_last),
    .rpi_running_o (rpi_running_o),
    .status_o      (status_o)
  );

  spi_byte_master spi_byte_master_inst (
    .rst         (rst),
    .clk         (clk),
    .tx_start_i  (tx_start),
    .tx_byte_i   (tx_byte),
    .tx_last_i   (tx_last),
    .miso_i      (miso_i),
    .sclk_o      (sclk_o),
    .mosi_o      (mosi_o),
    .spi_ss_n_o  (spi_ss_n_o),
    .byte_done_o (byte_done),
    .rx_byte_o   (rx_byte),
    .frame_end_o (frame_end)
  );

endmodule

`default_nettype wire

/* test/tb_robot_spi.sv */
// ------------------------------
// testbench for the spi command link,
// spi slave model and reference model
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_robot_spi;

  localparam int HALF_DIV      = spi_link_pkg::SPI_HALF_DIV;
  localparam int FRAME_TIMEOUT = 1000;

  // rst clocks the dut and clk resets it
  logic       rst = 1'b0;
  logic       clk;
  logic       btn2_i;
  logic       miso_i = 1'b0;
  wire        sclk_o;
  wire        mosi_o;
  wire        spi_ss_n_o;
  wire        rpi_running_o;
  wire  [7:0] status_o;

  int err_cnt;
  int check_cnt;

  // slave model state
  logic        prev_sclk;
  logic        prev_ss_n;
  logic        in_frame;
  int          phase_cnt;
  int          miso_idx;
  int          mosi_bits;
  logic        mosi_hold;
  logic [7:0]  miso_byte;
  logic [7:0]  mosi_sh;
  logic [31:0] rnd;
  logic [7:0]  cur_bytes[$];
  logic [7:0]  miso_bytes[$];
  // last closed frame
  logic [7:0]  frame_bytes[$];
  logic [7:0]  frame_status;
  int          frame_cnt;

  // reference copy of the setting registers
  int          ref_sel;
  logic [15:0] ref_dps_left;
  logic [15:0] ref_dps_rght;
  logic [23:0] ref_eye_left;
  logic [23:0] ref_eye_rght;
  logic [23:0] ref_blink_left;
  logic [23:0] ref_blink_rght;
  int          ref_servo_1;
  int          ref_servo_2;
  logic [7:0]  exp_bytes[$];

  robot_spi_top robot_spi_top_inst (
    .rst           (rst),
    .clk           (clk),
    .btn2_i        (btn2_i),
    .miso_i        (miso_i),
    .sclk_o        (sclk_o),
    .mosi_o        (mosi_o),
    .spi_ss_n_o    (spi_ss_n_o),
    .rpi_running_o (rpi_running_o),
    .status_o      (status_o)
  );

  initial begin
    forever #2 rst = ~rst;
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("FAILED time=%0t %s got=0x%0h exp=0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic note_failure(input string what);
    err_cnt++;
    $display("ERROR time=%0t %s", $time, what);
  endtask

  // next random reply byte from the slave
  task automatic load_miso_byte();
    rnd       = $urandom();
    miso_byte = rnd[7:0];
    miso_bytes.push_back(miso_byte);
  endtask

  // spi slave model sampled and driven on the system falling edge
  always @(negedge rst) begin
    if (clk) begin
      prev_sclk = 1'b0;
      prev_ss_n = 1'b1;
      in_frame  = 1'b0;
    end else begin
      if (prev_ss_n && !spi_ss_n_o) begin
        // frame opens and the reply msb goes out before the first rise
        cur_bytes.delete();
        miso_bytes.delete();
        in_frame  = 1'b1;
        phase_cnt = 1;
        mosi_bits = 0;
        load_miso_byte();
        miso_i   = miso_byte[7];
        miso_idx = 1;
      end else if (in_frame && spi_ss_n_o) begin
        // hold time after the last fall
        check_eq("spi_ss_n_o hold cycles", phase_cnt, HALF_DIV);
        check_eq("mosi_o bits after last byte", mosi_bits, 0);
        frame_bytes = cur_bytes;
        if (cur_bytes.size() > 0) begin
          frame_status = miso_bytes[cur_bytes.size() - 1];
        end else begin
          frame_status = 8'h00;
        end
        frame_cnt++;
        in_frame = 1'b0;
      end else if (in_frame && sclk_o != prev_sclk) begin
        check_eq("sclk_o phase cycles", phase_cnt, HALF_DIV);
        phase_cnt = 1;
        if (sclk_o) begin
          // rising sclk collects mosi msb first
          mosi_sh   = {mosi_sh[6:0], mosi_o};
          mosi_hold = mosi_o;
          mosi_bits++;
          if (mosi_bits == 8) begin
            cur_bytes.push_back(mosi_sh);
            mosi_bits = 0;
          end
        end else begin
          // falling sclk puts out the next reply bit
          if (miso_idx == 8) begin
            load_miso_byte();
            miso_idx = 0;
          end
          miso_i = miso_byte[7 - miso_idx];
          miso_idx++;
        end
      end else if (in_frame) begin
        phase_cnt++;
        if (sclk_o) begin
          check_eq("mosi_o while sclk_o high", mosi_o, mosi_hold);
        end
      end
      prev_sclk = sclk_o;
      prev_ss_n = spi_ss_n_o;
    end
  end

  // one press on the reference registers builds the expected frame
  task automatic step_model(output bit has_frame);
    logic [23:0] pay;
    int          n;
    pay = '0;
    n   = 0;
    exp_bytes.delete();
    case (ref_sel)
      3: begin
        ref_dps_left = (ref_dps_left >= 16'd900) ? 16'd0 : ref_dps_left + 16'd32;
        pay = {ref_dps_left, 8'h00};
        n   = spi_link_pkg::PAYLOAD_BYTES_DPS;
      end
      4: begin
        // unsigned compare keeps 0x8000 in place
        ref_dps_rght = (ref_dps_rght >= 16'd900) ? 16'h8000 : ref_dps_rght + 16'd400;
        pay = {ref_dps_rght, 8'h00};
        n   = spi_link_pkg::PAYLOAD_BYTES_DPS;
      end
      5: begin
        // blue
        if (ref_eye_left[7:0] >= 8'd64) begin
          ref_eye_left = '0;
        end else begin
          ref_eye_left[7:0] = ref_eye_left[7:0] + 8'd32;
        end
        pay = ref_eye_left;
        n   = spi_link_pkg::PAYLOAD_BYTES_RGB;
      end
      6: begin
        // green
        if (ref_eye_rght[15:8] >= 8'd64) begin
          ref_eye_rght = '0;
        end else begin
          ref_eye_rght[15:8] = ref_eye_rght[15:8] + 8'd32;
        end
        pay = ref_eye_rght;
        n   = spi_link_pkg::PAYLOAD_BYTES_RGB;
      end
      7: begin
        // red
        if (ref_blink_left[23:16] >= 8'd128) begin
          ref_blink_left = '0;
        end else begin
          ref_blink_left[23:16] = ref_blink_left[23:16] + 8'd32;
        end
        pay = ref_blink_left;
        n   = spi_link_pkg::PAYLOAD_BYTES_RGB;
      end
      8: begin
        // blue decides and all channels step
        if (ref_blink_rght[7:0] >= 8'd128) begin
          ref_blink_rght = '0;
        end else begin
          ref_blink_rght = {ref_blink_rght[23:16] + 8'd32,
                            ref_blink_rght[15:8] + 8'd32,
                            ref_blink_rght[7:0] + 8'd32};
        end
        pay = ref_blink_rght;
        n   = spi_link_pkg::PAYLOAD_BYTES_RGB;
      end
      9: begin
        ref_servo_1 = (ref_servo_1 >= 480) ? -500 : ref_servo_1 + 32;
        // two's complement sign extended to 16 bits
        pay = {ref_servo_1[15:0], 8'h00};
        n   = spi_link_pkg::PAYLOAD_BYTES_SERVO;
      end
      10: begin
        ref_servo_2 = (ref_servo_2 <= -480) ? 500 : ref_servo_2 - 32;
        pay = {ref_servo_2[15:0], 8'h00};
        n   = spi_link_pkg::PAYLOAD_BYTES_SERVO;
      end
      default: n = 0;
    endcase
    has_frame = (n != 0);
    if (has_frame) begin
      exp_bytes.push_back(8'(ref_sel));
      for (int i = 0; i < n; i++) begin
        exp_bytes.push_back(pay[23 - 8 * i -: 8]);
      end
    end
    // wraps after the second servo
    ref_sel = (ref_sel == 10) ? 0 : ref_sel + 1;
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (!spi_ss_n_o && cycles < FRAME_TIMEOUT) begin
      @(negedge rst);
      cycles++;
    end
    if (!spi_ss_n_o) begin
      note_failure("slave select still low after the timeout");
    end
  endtask

  task automatic pulse_button();
    btn2_i = 1'b1;
    repeat (4) @(negedge rst);
    btn2_i = 1'b0;
    repeat (4) @(negedge rst);
  endtask

  task automatic press_button();
    wait_idle();
    // busy drops one cycle after slave select rises
    repeat (2) @(negedge rst);
    pulse_button();
  endtask

  task automatic wait_frame(output bit ok);
    int start;
    int cycles;
    start  = frame_cnt;
    cycles = 0;
    while (frame_cnt == start && cycles < FRAME_TIMEOUT) begin
      @(negedge rst);
      cycles++;
    end
    ok = (frame_cnt != start);
    if (!ok) begin
      note_failure("no spi frame closed before the timeout");
    end
    // running flag follows frame end by a cycle
    repeat (2) @(negedge rst);
  endtask

  task automatic expect_frame();
    bit ok;
    int n;
    wait_frame(ok);
    if (ok) begin
      check_eq("frame byte count", frame_bytes.size(), exp_bytes.size());
      n = (frame_bytes.size() < exp_bytes.size()) ? frame_bytes.size() : exp_bytes.size();
      for (int i = 0; i < n; i++) begin
        check_eq($sformatf("mosi_o frame byte %0d", i), frame_bytes[i], exp_bytes[i]);
      end
      check_eq("status_o", status_o, frame_status);
      check_eq("rpi_running_o", rpi_running_o, 1);
    end
  endtask

  task automatic expect_no_frame();
    bit seen;
    seen = 1'b0;
    repeat (60) begin
      @(negedge rst);
      if (!spi_ss_n_o) begin
        seen = 1'b1;
      end
    end
    check_cnt++;
    assert (!seen) else note_failure("frame sent for a reserved opcode");
  endtask

  task automatic press_and_check();
    bit has_frame;
    press_button();
    step_model(has_frame);
    if (has_frame) begin
      expect_frame();
    end else begin
      expect_no_frame();
    end
  endtask

  task automatic check_after_reset();
    bit moved;
    moved = 1'b0;
    @(negedge rst);
    check_eq("sclk_o", sclk_o, 0);
    check_eq("mosi_o", mosi_o, 0);
    check_eq("spi_ss_n_o", spi_ss_n_o, 1);
    check_eq("rpi_running_o", rpi_running_o, 0);
    check_eq("status_o", status_o, 0);
    repeat (50) begin
      @(negedge rst);
      if (sclk_o || !spi_ss_n_o) begin
        moved = 1'b1;
      end
    end
    check_cnt++;
    assert (!moved) else note_failure("spi lines moved while idle after reset");
  endtask

  task automatic first_two_presses();
    press_and_check();
    // opcode 3 then speed 32 msb first
    check_eq("first frame size", frame_bytes.size(), 3);
    if (frame_bytes.size() == 3) begin
      check_eq("first frame opcode", frame_bytes[0], 3);
      check_eq("first frame payload", {frame_bytes[1], frame_bytes[2]}, 32);
    end
    check_eq("rpi_running_o", rpi_running_o, 1);
    press_and_check();
    check_eq("second frame size", frame_bytes.size(), 3);
    if (frame_bytes.size() == 3) begin
      check_eq("second frame opcode", frame_bytes[0], 4);
      check_eq("second frame payload", {frame_bytes[1], frame_bytes[2]}, 400);
    end
  endtask

  task automatic press_sequence();
    repeat (30) begin
      press_and_check();
    end
  endtask

  task automatic press_in_flight();
    bit has_frame;
    // park where this press and the next one both send frames
    while (ref_sel < 3 || ref_sel == 10) begin
      press_and_check();
    end
    press_button();
    step_model(has_frame);
    check_eq("spi_ss_n_o during frame", spi_ss_n_o, 0);
    // this press lands while busy and is dropped
    pulse_button();
    expect_frame();
    press_and_check();
  endtask

  initial begin
    void'($urandom(32'h129a));
    btn2_i         = 1'b0;
    clk            = 1'b1;
    err_cnt        = 0;
    check_cnt      = 0;
    frame_cnt      = 0;
    frame_status   = 8'h00;
    mosi_sh        = 8'h00;
    ref_sel        = 3;
    ref_dps_left   = '0;
    ref_dps_rght   = '0;
    ref_eye_left   = '0;
    ref_eye_rght   = '0;
    ref_blink_left = '0;
    ref_blink_rght = '0;
    ref_servo_1    = 0;
    ref_servo_2    = 0;
    repeat (5) @(negedge rst);
    clk = 1'b0;

    check_after_reset();
    first_two_presses();
    // enough presses for every wrap as the left wheel takes longest
    repeat (12) press_sequence();
    press_in_flight();

    $display("errors %0d, checks %0d", err_cnt, check_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
source/robot_cmd_pkg.sv
source/spi_link_pkg.sv
source/btn_cmd_stepper.sv
source/cmd_frame_builder.sv
source/spi_byte_master.sv
source/robot_spi_top.sv
test/tb_robot_spi.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with verilator, run, then scan the log for the fail message
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/100ps \
  --top-module tb_robot_spi \
  -f tb.f \
  -o tb_robot_spi

./obj_dir/tb_robot_spi | tee sim.log

if grep -q "TB FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
exit 0
